/* design/hart_pkg.sv */
`default_nettype none

package hart_pkg;

    //////////////////////////////
    // Widths and types
    //////////////////////////////
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    // Sequential fetch only
    localparam word_t RESET_ADDR  = 32'h0000_0000;
    localparam word_t INSTR_BYTES = 32'd4;

    //////////////////////////////
    // Encodings
    //////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // ALU operations, pass-b carries the LUI immediate
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire               i_clk,
    input  wire               i_arst_n,
    input  wire hart_pkg::word_t i_imem_rdata,
    output hart_pkg::word_t   o_imem_raddr,
    output logic              o_valid,
    output hart_pkg::word_t   o_pc,
    output hart_pkg::word_t   o_inst
);

    hart_pkg::word_t pc;

    // No branches, the pc only counts up
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= hart_pkg::RESET_ADDR;
            o_valid <= 1'b0;
        end else begin
            pc      <= pc + hart_pkg::INSTR_BYTES;
            o_valid <= 1'b1;
        end
    end

    // Memory read is combinational, capture word with its address
    always_ff @(posedge i_clk) begin
        o_pc   <= pc;
        o_inst <= i_imem_rdata;
    end

    assign o_imem_raddr = pc;

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  wire hart_pkg::reg_addr_t i_rs1_addr,
    input  wire hart_pkg::reg_addr_t i_rs2_addr,
    input  wire                     i_wen,
    input  wire hart_pkg::reg_addr_t i_rd_addr,
    input  wire hart_pkg::word_t    i_rd_data,
    output hart_pkg::word_t         o_rs1_data,
    output hart_pkg::word_t         o_rs2_data
);

    hart_pkg::word_t regs [hart_pkg::NUM_REGS];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < hart_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wen && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // x0 first, then the write in flight, then storage
    function automatic hart_pkg::word_t read_port(input hart_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wen && (addr == i_rd_addr)) begin
            return i_rd_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

    a_zero_reg_stays_zero : assert property (
        @(posedge i_clk) disable iff (!i_arst_n) regs[0] == '0
    );

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  wire                     i_valid,
    input  wire hart_pkg::word_t    i_pc,
    input  wire hart_pkg::word_t    i_inst,
    input  wire hart_pkg::word_t    i_rs1_data,
    input  wire hart_pkg::word_t    i_rs2_data,
    output hart_pkg::reg_addr_t     o_rs1_addr,
    output hart_pkg::reg_addr_t     o_rs2_addr,
    output logic                    o_valid,
    output hart_pkg::word_t         o_pc,
    output hart_pkg::word_t         o_inst,
    output hart_pkg::reg_addr_t     o_rd_addr,
    output logic                    o_wen,
    output hart_pkg::alu_op_e       o_alu_op,
    output hart_pkg::word_t         o_op_a,
    output hart_pkg::word_t         o_op_b
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7_b5;
    hart_pkg::word_t   imm_i;
    hart_pkg::word_t   imm_u;
    logic              dec_wen;
    hart_pkg::alu_op_e dec_alu_op;
    hart_pkg::word_t   dec_op_a;
    hart_pkg::word_t   dec_op_b;

    //////////////////////////////
    // Field extraction
    //////////////////////////////
    assign opcode     = i_inst[6:0];
    assign funct3     = i_inst[14:12];
    assign funct7_b5  = i_inst[30];
    assign o_rs1_addr = i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20];

    assign imm_i = {{(hart_pkg::XLEN-12){i_inst[31]}}, i_inst[31:20]};
    assign imm_u = {i_inst[31:12], 12'b0};

    // Shared by OP and OP-IMM, alt picks sub or sra
    function automatic hart_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                          input logic       alt);
        case (f3)
            hart_pkg::F3_ADD_SUB: return alt ? hart_pkg::ALU_SUB : hart_pkg::ALU_ADD;
            hart_pkg::F3_SLL:     return hart_pkg::ALU_SLL;
            hart_pkg::F3_SLT:     return hart_pkg::ALU_SLT;
            hart_pkg::F3_SLTU:    return hart_pkg::ALU_SLTU;
            hart_pkg::F3_XOR:     return hart_pkg::ALU_XOR;
            hart_pkg::F3_SRL_SRA: return alt ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL;
            hart_pkg::F3_OR:      return hart_pkg::ALU_OR;
            default:              return hart_pkg::ALU_AND;
        endcase
    endfunction

    //////////////////////////////
    // Control decode
    //////////////////////////////
    always_comb begin
        dec_wen    = 1'b0;
        dec_alu_op = hart_pkg::ALU_ADD;
        dec_op_a   = i_rs1_data;
        dec_op_b   = i_rs2_data;
        case (opcode)
            hart_pkg::OPC_OP: begin
                dec_wen    = 1'b1;
                dec_alu_op = alu_from_funct3(funct3, funct7_b5);
            end
            hart_pkg::OPC_OP_IMM: begin
                // Only the right shift looks at bit 30, addi has no subtract
                dec_wen    = 1'b1;
                dec_alu_op = alu_from_funct3(funct3,
                                             funct7_b5 && (funct3 == hart_pkg::F3_SRL_SRA));
                dec_op_b   = imm_i;
            end
            hart_pkg::OPC_LUI: begin
                dec_wen    = 1'b1;
                dec_alu_op = hart_pkg::ALU_PASS_B;
                dec_op_a   = '0;
                dec_op_b   = imm_u;
            end
            // Unknown opcode retires as a no-op
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid  <= 1'b0;
            o_wen    <= 1'b0;
            o_alu_op <= hart_pkg::ALU_ADD;
        end else begin
            o_valid  <= i_valid;
            o_wen    <= i_valid && dec_wen;
            o_alu_op <= dec_alu_op;
        end
    end

    always_ff @(posedge i_clk) begin
        o_pc      <= i_pc;
        o_inst    <= i_inst;
        o_rd_addr <= i_inst[11:7];
        o_op_a    <= dec_op_a;
        o_op_b    <= dec_op_b;
    end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  wire                     i_valid,
    input  wire hart_pkg::word_t    i_pc,
    input  wire hart_pkg::word_t    i_inst,
    input  wire hart_pkg::reg_addr_t i_rd_addr,
    input  wire                     i_wen,
    input  wire hart_pkg::alu_op_e  i_alu_op,
    input  wire hart_pkg::word_t    i_op_a,
    input  wire hart_pkg::word_t    i_op_b,
    output logic                    o_valid,
    output hart_pkg::word_t         o_pc,
    output hart_pkg::word_t         o_inst,
    output hart_pkg::reg_addr_t     o_rd_addr,
    output logic                    o_wen,
    output hart_pkg::word_t         o_result
);

    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    hart_pkg::word_t alu_result;

    //////////////////////////////
    // ALU
    //////////////////////////////
    assign shamt       = i_op_b[4:0];
    assign lt_signed   = $signed(i_op_a) < $signed(i_op_b);
    assign lt_unsigned = i_op_a < i_op_b;

    always_comb begin
        case (i_alu_op)
            hart_pkg::ALU_ADD:    alu_result = i_op_a + i_op_b;
            hart_pkg::ALU_SUB:    alu_result = i_op_a - i_op_b;
            hart_pkg::ALU_SLL:    alu_result = i_op_a << shamt;
            hart_pkg::ALU_SLT:    alu_result = {{(hart_pkg::XLEN-1){1'b0}}, lt_signed};
            hart_pkg::ALU_SLTU:   alu_result = {{(hart_pkg::XLEN-1){1'b0}}, lt_unsigned};
            hart_pkg::ALU_XOR:    alu_result = i_op_a ^ i_op_b;
            hart_pkg::ALU_SRL:    alu_result = i_op_a >> shamt;
            // Arithmetic shift keeps the sign of operand a
            hart_pkg::ALU_SRA:    alu_result = $signed(i_op_a) >>> shamt;
            hart_pkg::ALU_OR:     alu_result = i_op_a | i_op_b;
            hart_pkg::ALU_AND:    alu_result = i_op_a & i_op_b;
            hart_pkg::ALU_PASS_B: alu_result = i_op_b;
            default:              alu_result = '0;
        endcase
    end

    //////////////////////////////
    // Execute to writeback
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
            o_wen   <= 1'b0;
        end else begin
            o_valid <= i_valid;
            o_wen   <= i_wen;
        end
    end

    always_ff @(posedge i_clk) begin
        o_pc      <= i_pc;
        o_inst    <= i_inst;
        o_rd_addr <= i_rd_addr;
        o_result  <= alu_result;
    end

    // Decode must hand over a real operation with every valid instruction
    a_alu_op_defined : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        i_valid |-> !$isunknown(i_alu_op) && (i_alu_op <= hart_pkg::ALU_PASS_B)
    );

endmodule

`default_nettype wire

/* design/hart.sv */
`timescale 1ns/1ps
`default_nettype none

module hart (
    input  wire                  i_clk,
    input  wire                  i_arst_n,
    input  wire hart_pkg::word_t i_imem_rdata,
    output hart_pkg::word_t      o_imem_raddr,
    output logic                 o_retire_valid,
    output hart_pkg::word_t      o_retire_pc,
    output hart_pkg::word_t      o_retire_inst,
    output hart_pkg::reg_addr_t  o_retire_rd_waddr,
    output hart_pkg::word_t      o_retire_rd_wdata
);

    logic                f_valid;
    hart_pkg::word_t     f_pc;
    hart_pkg::word_t     f_inst;

    hart_pkg::reg_addr_t d_rs1_addr;
    hart_pkg::reg_addr_t d_rs2_addr;
    hart_pkg::word_t     d_rs1_data;
    hart_pkg::word_t     d_rs2_data;
    logic                d_valid;
    hart_pkg::word_t     d_pc;
    hart_pkg::word_t     d_inst;
    hart_pkg::reg_addr_t d_rd_addr;
    logic                d_wen;
    hart_pkg::alu_op_e   d_alu_op;
    hart_pkg::word_t     d_op_a;
    hart_pkg::word_t     d_op_b;

    logic                w_valid;
    hart_pkg::word_t     w_pc;
    hart_pkg::word_t     w_inst;
    hart_pkg::reg_addr_t w_rd_addr;
    logic                w_wen;
    hart_pkg::word_t     w_result;
    logic                rf_wen;

    //////////////////////////////
    // Fetch
    //////////////////////////////
    fetch_stage u_fetch (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_imem_rdata (i_imem_rdata),
        .o_imem_raddr (o_imem_raddr),
        .o_valid      (f_valid),
        .o_pc         (f_pc),
        .o_inst       (f_inst)
    );

    //////////////////////////////
    // Decode and register file
    //////////////////////////////
    decode_stage u_decode (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_valid    (f_valid),
        .i_pc       (f_pc),
        .i_inst     (f_inst),
        .i_rs1_data (d_rs1_data),
        .i_rs2_data (d_rs2_data),
        .o_rs1_addr (d_rs1_addr),
        .o_rs2_addr (d_rs2_addr),
        .o_valid    (d_valid),
        .o_pc       (d_pc),
        .o_inst     (d_inst),
        .o_rd_addr  (d_rd_addr),
        .o_wen      (d_wen),
        .o_alu_op   (d_alu_op),
        .o_op_a     (d_op_a),
        .o_op_b     (d_op_b)
    );

    // Writeback port, only bypass path in the pipeline
    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs1_addr (d_rs1_addr),
        .i_rs2_addr (d_rs2_addr),
        .i_wen      (rf_wen),
        .i_rd_addr  (w_rd_addr),
        .i_rd_data  (w_result),
        .o_rs1_data (d_rs1_data),
        .o_rs2_data (d_rs2_data)
    );

    //////////////////////////////
    // Execute
    //////////////////////////////
    execute_stage u_execute (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_valid   (d_valid),
        .i_pc      (d_pc),
        .i_inst    (d_inst),
        .i_rd_addr (d_rd_addr),
        .i_wen     (d_wen),
        .i_alu_op  (d_alu_op),
        .i_op_a    (d_op_a),
        .i_op_b    (d_op_b),
        .o_valid   (w_valid),
        .o_pc      (w_pc),
        .o_inst    (w_inst),
        .o_rd_addr (w_rd_addr),
        .o_wen     (w_wen),
        .o_result  (w_result)
    );

    //////////////////////////////
    // Writeback and retire
    //////////////////////////////
    assign rf_wen = w_valid && w_wen;

    assign o_retire_valid    = w_valid;
    assign o_retire_pc       = w_pc;
    assign o_retire_inst     = w_inst;
    assign o_retire_rd_waddr = rf_wen ? w_rd_addr : '0;
    assign o_retire_rd_wdata = w_result;

endmodule

`default_nettype wire

/* dv/tb_hart.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hart;

    localparam int          CLK_PERIOD = 20;
    localparam int          PROG_WORDS = 64;
    localparam int          TEST_COUNT = 5;
    localparam int          WATCHDOG_CYCLES = TEST_COUNT * PROG_WORDS * 4 + 100;
    localparam logic [6:0]  OPC_OP     = 7'b0110011;
    localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0]  OPC_LUI    = 7'b0110111;
    localparam logic [6:0]  OPC_CUSTOM = 7'b0001011;
    localparam logic [31:0] NOP        = 32'h0000_0013;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] imem_rdata;
    logic [31:0] imem_raddr;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_inst;
    logic [4:0]  retire_rd_waddr;
    logic [31:0] retire_rd_wdata;

    // Program and the retire stream it should produce
    logic [31:0] imem     [PROG_WORDS];
    logic [4:0]  exp_rd   [PROG_WORDS];
    logic [31:0] exp_data [PROG_WORDS];
    int          prog_len;
    logic [31:0] lfsr_state = 32'h75b1_ed07;

    hart DUT (
        .i_clk             (clk),
        .i_arst_n          (arst_n),
        .i_imem_rdata      (imem_rdata),
        .o_imem_raddr      (imem_raddr),
        .o_retire_valid    (retire_valid),
        .o_retire_pc       (retire_pc),
        .o_retire_inst     (retire_inst),
        .o_retire_rd_waddr (retire_rd_waddr),
        .o_retire_rd_wdata (retire_rd_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Past the end of the program the hart sees no-ops
    always @(negedge clk) begin
        if (imem_raddr[31:2] < 30'(prog_len)) begin
            imem_rdata <= imem[imem_raddr[7:2]];
        end else begin
            imem_rdata <= NOP;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            // Taps 32 22 2 1
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // Expected result straight from the ISA rules
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return (a[31] != b[31]) ? 32'(a[31]) : 32'(a < b);
            3'd3:    return 32'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic emit(input logic [31:0] inst, input logic [4:0] rd, input logic [31:0] data);
        imem[prog_len]     = inst;
        exp_rd[prog_len]   = rd;
        exp_data[prog_len] = data;
        prog_len++;
    endtask

    task automatic nop();
        emit(NOP, 5'd0, 32'd0);
    endtask

    // LUI then ADDI, each followed by a no-op so the next reader sees the value
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        emit(enc_u(hi[31:12], rd), rd, {hi[31:12], 12'b0});
        nop();
        emit(enc_i(v[11:0], rd, 3'd0, rd, OPC_OP_IMM), rd, v);
        nop();
    endtask

    //////////////////////////////
    // Reset, run, compare
    //////////////////////////////
    task automatic run_program(input string name);
        string tag;
        @(negedge clk);
        arst_n <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check({name, " retire during reset"}, 32'd0, 32'(retire_valid));
        end
        arst_n <= 1'b1;
        // Two cycles of fill before the first retire
        repeat (2) begin
            @(negedge clk);
            check({name, " early retire"}, 32'd0, 32'(retire_valid));
        end
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            tag = $sformatf("%s slot %0d", name, i);
            check({tag, " valid"}, 32'd1, 32'(retire_valid));
            check({tag, " pc"}, 32'(4 * i), retire_pc);
            check({tag, " inst"}, imem[i], retire_inst);
            check({tag, " rd_waddr"}, 32'(exp_rd[i]), 32'(retire_rd_waddr));
            if (exp_rd[i] != 5'd0) begin
                check({tag, " rd_wdata"}, exp_data[i], retire_rd_wdata);
            end
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic test_reset_order();
        logic [11:0] imm;
        prog_len = 0;
        for (int k = 1; k <= 6; k++) begin
            imm = 12'(rand_bits(12));
            emit(enc_i(imm, 5'd0, 3'd0, 5'(k), OPC_OP_IMM), 5'(k), {{20{imm[11]}}, imm});
        end
        run_program("reset_order");
    endtask

    task automatic test_imm_ops();
        logic [31:0] a;
        logic [11:0] imm;
        logic [19:0] u;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        prog_len = 0;
        for (int round = 0; round < 2; round++) begin
            a = rand_bits(32);
            if (round == 0) begin
                a[31] = 1'b1;
            end
            load_reg(5'd1, a);
            // Index 8 stands for SRAI
            for (int f = 0; f < 9; f++) begin
                f3  = (f == 8) ? 3'd5 : 3'(f);
                alt = (f == 8);
                rd  = 5'(2 + f);
                imm = 12'(rand_bits(12));
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm[11:5] = alt ? 7'b0100000 : 7'b0000000;
                end
                emit(enc_i(imm, 5'd1, f3, rd, OPC_OP_IMM), rd,
                     ref_alu(f3, alt, a, {{20{imm[11]}}, imm}));
            end
            u = 20'(rand_bits(20));
            emit(enc_u(u, 5'd11), 5'd11, {u, 12'b0});
        end
        run_program("imm_ops");
    endtask

    task automatic test_reg_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        prog_len = 0;
        for (int round = 0; round < 2; round++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            a[31] = (round == 0);
            b[31] = (round != 0);
            load_reg(5'd1, a);
            load_reg(5'd2, b);
            // 8 is SUB and 9 is SRA
            for (int f = 0; f < 10; f++) begin
                f3  = (f == 8) ? 3'd0 : ((f == 9) ? 3'd5 : 3'(f));
                alt = (f >= 8);
                rd  = 5'(3 + f);
                emit(enc_r(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, rd), rd,
                     ref_alu(f3, alt, a, b));
            end
        end
        run_program("reg_ops");
    endtask

    task automatic test_bypass();
        logic [11:0] i1;
        logic [11:0] i2;
        logic [31:0] v1;
        logic [31:0] v2;
        prog_len = 0;
        i1 = 12'(rand_bits(12));
        i2 = 12'(rand_bits(12));
        v1 = {{20{i1[11]}}, i1};
        v2 = {{20{i2[11]}}, i2};
        emit(enc_i(i1, 5'd0, 3'd0, 5'd2, OPC_OP_IMM), 5'd2, v1);
        nop();
        nop();
        emit(enc_i(i2, 5'd0, 3'd0, 5'd2, OPC_OP_IMM), 5'd2, v2);
        // Directly after the writer, the old x2
        emit(enc_i(12'd0, 5'd2, 3'd0, 5'd3, OPC_OP_IMM), 5'd3, v1);
        emit(enc_i(12'd0, 5'd2, 3'd0, 5'd4, OPC_OP_IMM), 5'd4, v2);
        // x4 is still the reset value here
        emit(enc_r(7'd0, 5'd4, 5'd2, 3'd0, 5'd5), 5'd5, v2);
        nop();
        nop();
        emit(enc_r(7'd0, 5'd4, 5'd3, 3'd0, 5'd6), 5'd6, v1 + v2);
        run_program("bypass");
    endtask

    task automatic test_zero_unknown();
        prog_len = 0;
        emit(enc_i(12'h05a, 5'd0, 3'd0, 5'd0, OPC_OP_IMM), 5'd0, 32'd0);
        emit(enc_u(20'(rand_bits(20)), 5'd0), 5'd0, 32'd0);
        nop();
        emit(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd7), 5'd7, 32'd0);
        emit(enc_i(12'h055, 5'd0, 3'd0, 5'd9, OPC_OP_IMM), 5'd9, 32'h55);
        nop();
        nop();
        // Unsupported opcode aimed at x9, its sources add up to 0
        emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd9, OPC_CUSTOM), 5'd0, 32'd0);
        nop();
        nop();
        emit(enc_i(12'd0, 5'd9, 3'd0, 5'd10, OPC_OP_IMM), 5'd10, 32'h55);
        run_program("zero_unknown");
    endtask

    //////////////////////////////
    // Sequence and watchdog
    //////////////////////////////
    initial begin
        arst_n     = 1'b0;
        imem_rdata = NOP;
        prog_len   = 0;
        test_reset_order();
        test_imm_ops();
        test_reg_ops();
        test_bypass();
        test_zero_unknown();
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* build.f */
design/hart_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/hart.sv
dv/tb_hart.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_hart -f build.f
	@out="$$(./obj_dir/Vtb_hart)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
